//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		F3_LB  = 3'd0,
		F3_LH  = 3'd1,
		F3_LW  = 3'd2,
		F3_LBU = 3'd4,
		F3_LHU = 3'd5
	} funct3_load_e;

	typedef enum logic [2:0] {
		F3_SB = 3'd0,
		F3_SH = 3'd1,
		F3_SW = 3'd2
	} funct3_store_e;

	// also shared by OP: add/sub on 0, srl/sra on 5
	typedef enum logic [2:0] {
		F3_ADDI  = 3'd0,
		F3_SLLI  = 3'd1,
		F3_SLTI  = 3'd2,
		F3_SLTIU = 3'd3,
		F3_XORI  = 3'd4,
		F3_SRLI  = 3'd5,  // srli and srai
		F3_ORI   = 3'd6,
		F3_ANDI  = 3'd7
	} funct3_imm_e;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;  // sub, sra, srai

	// r-type layout, other formats reuse the same bit positions
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_fields_t;

	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

endpackage

`default_nettype wire

//--- logic/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} axi_resp_e;

	// master to slave
	typedef struct packed {
		logic        ar_valid;
		logic [31:0] ar_addr;
		logic        r_ready;
		logic        aw_valid;
		logic [31:0] aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic [3:0]  w_strb;
		logic        b_ready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		axi_resp_e   r_resp;
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		axi_resp_e   b_resp;
	} axil_rsp_t;

	// one load or store from the execute stage
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} lsu_req_t;

endpackage

`default_nettype wire

//--- logic/inst_check.sv
`timescale 1ns/1ps
`default_nettype none

module inst_check (
	input  logic [31:0] inst_i,
	output logic        illegal_o
);
	import rv_isa_pkg::*;

	inst_fields_t f;
	logic         f7_base;
	logic         f7_alt;
	logic         legal;

	assign f       = inst_fields_t'(inst_i);
	assign f7_base = (f.funct7 == F7_BASE);
	assign f7_alt  = (f.funct7 == F7_ALT);

	always_comb begin
		legal = 1'b0;
		case (opcode_e'(f.opcode))
			LUI, AUIPC, JAL: legal = 1'b1;
			JALR:   legal = (f.funct3 == 3'd0);
			BRANCH: legal = (f.funct3 != 3'd2) && (f.funct3 != 3'd3);  // no encoding on 2, 3
			LOAD: begin
				case (funct3_load_e'(f.funct3))
					F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			STORE: begin
				case (funct3_store_e'(f.funct3))
					F3_SB, F3_SH, F3_SW: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			OP_IMM: begin
				// only shifts carry funct7 in the immediate
				case (funct3_imm_e'(f.funct3))
					F3_SLLI: legal = f7_base;
					F3_SRLI: legal = f7_base || f7_alt;
					default: legal = 1'b1;
				endcase
			end
			OP: begin
				legal = f7_base ||
					(f7_alt && (f.funct3 == F3_ADDI || f.funct3 == F3_SRLI));  // sub, sra
			end
			SYSTEM: begin
				legal = (inst_i == INST_ECALL) || (inst_i == INST_EBREAK) ||
					(inst_i == INST_MRET);
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal_o = !legal;

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    fetch_en_i,
	input  logic                    redirect_valid_i,
	input  logic [31:0]             redirect_pc_i,
	input  logic                    inst_ready_i,
	output logic                    inst_valid_o,
	output logic [31:0]             inst_o,
	output logic [31:0]             inst_pc_o,
	output logic                    inst_illegal_o,
	output logic                    inst_fault_o,
	output axi_lite_pkg::axil_req_t bus_req_o,
	input  axi_lite_pkg::axil_rsp_t bus_rsp_i
);
	import axi_lite_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR, DATA, HOLD} state_e;

	state_e      state_q;
	state_e      resume;
	logic [31:0] pc_q;       // address of the word in flight or on offer
	logic [31:0] next_pc_q;  // redirect target parked behind a live read
	logic        discard_q;
	logic [31:0] inst_q;
	logic        fault_q;
	logic        r_fire;
	logic        drop_rd;

	assign r_fire  = (state_q == DATA) && bus_rsp_i.r_valid;
	assign drop_rd = discard_q || redirect_valid_i;
	assign resume  = fetch_en_i ? ADDR : IDLE;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= IDLE;
			pc_q      <= RESET_PC;
			discard_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (redirect_valid_i)
						pc_q <= redirect_pc_i;
					if (fetch_en_i)
						state_q <= ADDR;
				end
				ADDR: begin
					// ar is already up, so the address must not move
					if (redirect_valid_i)
						discard_q <= 1'b1;
					if (bus_rsp_i.ar_ready)
						state_q <= DATA;
				end
				DATA: begin
					if (r_fire) begin
						if (drop_rd) begin
							pc_q      <= redirect_valid_i ? redirect_pc_i : next_pc_q;
							discard_q <= 1'b0;
							state_q   <= resume;
						end else begin
							state_q <= HOLD;
						end
					end else if (redirect_valid_i) begin
						discard_q <= 1'b1;
					end
				end
				HOLD: begin
					if (redirect_valid_i) begin
						pc_q    <= redirect_pc_i;  // word on offer is dropped
						state_q <= resume;
					end else if (inst_ready_i) begin
						pc_q    <= pc_q + 32'd4;
						state_q <= resume;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_valid_i)
			next_pc_q <= redirect_pc_i;
		if (r_fire && !drop_rd) begin
			inst_q  <= bus_rsp_i.r_data;
			fault_q <= (bus_rsp_i.r_resp == SLVERR);
		end
	end

	always_comb begin
		bus_req_o          = '0;  // read only master
		bus_req_o.ar_valid = (state_q == ADDR);
		bus_req_o.ar_addr  = pc_q;
		bus_req_o.r_ready  = (state_q == DATA);
	end

	inst_check i_inst_check (
		.inst_i    (inst_q),
		.illegal_o (inst_illegal_o)
	);

	assign inst_valid_o = (state_q == HOLD);
	assign inst_o       = inst_q;
	assign inst_pc_o    = pc_q;
	assign inst_fault_o = fault_q;

endmodule

`default_nettype wire

//--- logic/lsu_port.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_port (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    lsu_req_valid_i,
	input  axi_lite_pkg::lsu_req_t  lsu_req_i,
	output logic                    lsu_req_ready_o,
	output logic                    lsu_rsp_valid_o,
	output logic                    lsu_err_o,
	output logic [31:0]             lsu_rdata_o,
	output axi_lite_pkg::axil_req_t bus_req_o,
	input  axi_lite_pkg::axil_rsp_t bus_rsp_i
);
	import axi_lite_pkg::*;

	typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_REQ, WR_RESP} state_e;

	state_e      state_q;
	lsu_req_t    req_q;
	logic [31:0] word_addr;
	logic        rsp_valid_q;
	logic        err_q;
	logic [31:0] rdata_q;
	logic        r_fire;
	logic        b_fire;

	assign lsu_req_ready_o = (state_q == IDLE);
	assign r_fire          = (state_q == RD_DATA) && bus_rsp_i.r_valid;
	assign b_fire          = (state_q == WR_RESP) && bus_rsp_i.b_valid;
	assign word_addr       = {req_q.addr[31:2], 2'b00};  // byte lanes come from strb

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q     <= IDLE;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= r_fire || b_fire;  // single cycle pulse
			case (state_q)
				IDLE: begin
					if (lsu_req_valid_i)
						state_q <= lsu_req_i.write ? WR_REQ : RD_ADDR;
				end
				RD_ADDR: if (bus_rsp_i.ar_ready) state_q <= RD_DATA;
				RD_DATA: if (r_fire) state_q <= IDLE;
				WR_REQ:  if (bus_rsp_i.aw_ready && bus_rsp_i.w_ready) state_q <= WR_RESP;
				WR_RESP: if (b_fire) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lsu_req_valid_i && lsu_req_ready_o)
			req_q <= lsu_req_i;
		if (r_fire) begin
			rdata_q <= bus_rsp_i.r_data;
			err_q   <= (bus_rsp_i.r_resp == SLVERR);
		end else if (b_fire) begin
			rdata_q <= '0;
			err_q   <= (bus_rsp_i.b_resp == SLVERR);
		end
	end

	always_comb begin
		bus_req_o          = '0;
		bus_req_o.ar_valid = (state_q == RD_ADDR);
		bus_req_o.ar_addr  = word_addr;
		bus_req_o.r_ready  = (state_q == RD_DATA);
		// aw and w always go up together
		bus_req_o.aw_valid = (state_q == WR_REQ);
		bus_req_o.aw_addr  = word_addr;
		bus_req_o.w_valid  = (state_q == WR_REQ);
		bus_req_o.w_data   = req_q.wdata;
		bus_req_o.w_strb   = req_q.strb;
		bus_req_o.b_ready  = (state_q == WR_RESP);
	end

	assign lsu_rsp_valid_o = rsp_valid_q;
	assign lsu_rdata_o     = rdata_q;
	assign lsu_err_o       = err_q;

endmodule

`default_nettype wire

//--- logic/axi_lite_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter (
	input  logic                    clk,
	input  logic                    rst,
	input  axi_lite_pkg::axil_req_t m0_req_i,
	input  axi_lite_pkg::axil_req_t m1_req_i,
	output axi_lite_pkg::axil_rsp_t m0_rsp_o,
	output axi_lite_pkg::axil_rsp_t m1_rsp_o,
	output axi_lite_pkg::axil_req_t s_req_o,
	input  axi_lite_pkg::axil_rsp_t s_rsp_i
);
	import axi_lite_pkg::*;

	typedef enum logic [1:0] {NONE, M0, M1} grant_e;

	grant_e grant_q;
	logic   last_m1_q;  // master 1 won the previous round
	logic   m0_pend;
	logic   m1_pend;
	logic   done;

	assign m0_pend = m0_req_i.ar_valid || m0_req_i.aw_valid;
	assign m1_pend = m1_req_i.ar_valid || m1_req_i.aw_valid;

	// closing handshake of the granted transaction
	assign done = (s_rsp_i.r_valid && s_req_o.r_ready) ||
		(s_rsp_i.b_valid && s_req_o.b_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q   <= NONE;
			last_m1_q <= 1'b1;  // master 0 goes first
		end else begin
			case (grant_q)
				NONE: begin
					if (m0_pend && (!m1_pend || last_m1_q))
						grant_q <= M0;
					else if (m1_pend)
						grant_q <= M1;
				end
				M0, M1: begin
					if (done) begin
						grant_q   <= NONE;
						last_m1_q <= (grant_q == M1);
					end
				end
				default: grant_q <= NONE;
			endcase
		end
	end

	// loser sees every ready low
	always_comb begin
		s_req_o  = '0;
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		case (grant_q)
			M0: begin
				s_req_o  = m0_req_i;
				m0_rsp_o = s_rsp_i;
			end
			M1: begin
				s_req_o  = m1_req_i;
				m1_rsp_o = s_rsp_i;
			end
			default: s_req_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/axi_lite_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_sram #(
	parameter int MEM_WORDS = 256
) (
	input  logic                    clk,
	input  logic                    rst,
	input  axi_lite_pkg::axil_req_t s_req_i,
	output axi_lite_pkg::axil_rsp_t s_rsp_o
);
	import axi_lite_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	logic [31:0]      mem [MEM_WORDS];
	logic             r_valid_q;
	logic             b_valid_q;
	logic [31:0]      r_data_q;
	axi_resp_e        r_resp_q;
	axi_resp_e        b_resp_q;
	logic             rd_fire;
	logic             wr_fire;
	logic             rd_hit;
	logic             wr_hit;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// one response in flight per direction
	assign rd_fire = s_req_i.ar_valid && !r_valid_q;
	assign wr_fire = s_req_i.aw_valid && s_req_i.w_valid && !b_valid_q;

	assign rd_hit = (s_req_i.ar_addr[31:2] < 30'(MEM_WORDS));
	assign wr_hit = (s_req_i.aw_addr[31:2] < 30'(MEM_WORDS));
	assign rd_idx = s_req_i.ar_addr[IDX_W+1:2];
	assign wr_idx = s_req_i.aw_addr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_fire)
				r_valid_q <= 1'b1;
			else if (s_req_i.r_ready)
				r_valid_q <= 1'b0;
			if (wr_fire)
				b_valid_q <= 1'b1;
			else if (s_req_i.b_ready)
				b_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_data_q <= rd_hit ? mem[rd_idx] : '0;
			r_resp_q <= rd_hit ? OKAY : SLVERR;
		end
		if (wr_fire) begin
			b_resp_q <= wr_hit ? OKAY : SLVERR;
			for (int b = 0; b < 4; b++) begin
				if (wr_hit && s_req_i.w_strb[b])
					mem[wr_idx][8*b +: 8] <= s_req_i.w_data[8*b +: 8];
			end
		end
	end

	always_comb begin
		s_rsp_o.ar_ready = !r_valid_q;
		s_rsp_o.r_valid  = r_valid_q;
		s_rsp_o.r_data   = r_data_q;
		s_rsp_o.r_resp   = r_resp_q;
		s_rsp_o.aw_ready = wr_fire;  // address and data taken together
		s_rsp_o.w_ready  = wr_fire;
		s_rsp_o.b_valid  = b_valid_q;
		s_rsp_o.b_resp   = b_resp_q;
	end

endmodule

`default_nettype wire

//--- logic/fetch_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_top #(
	parameter logic [31:0] RESET_PC  = 32'h0,
	parameter int          MEM_WORDS = 256
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   fetch_en_i,
	input  logic                   redirect_valid_i,
	input  logic [31:0]            redirect_pc_i,
	input  logic                   inst_ready_i,
	output logic                   inst_valid_o,
	output logic [31:0]            inst_o,
	output logic [31:0]            inst_pc_o,
	output logic                   inst_illegal_o,
	output logic                   inst_fault_o,
	input  logic                   lsu_req_valid_i,
	input  axi_lite_pkg::lsu_req_t lsu_req_i,
	output logic                   lsu_req_ready_o,
	output logic                   lsu_rsp_valid_o,
	output logic                   lsu_err_o,
	output logic [31:0]            lsu_rdata_o
);
	import axi_lite_pkg::*;

	axil_req_t fetch_bus_req;
	axil_rsp_t fetch_bus_rsp;
	axil_req_t lsu_bus_req;
	axil_rsp_t lsu_bus_rsp;
	axil_req_t mem_req;
	axil_rsp_t mem_rsp;

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) i_fetch_unit (
		.clk              (clk),
		.rst              (rst),
		.fetch_en_i       (fetch_en_i),
		.redirect_valid_i (redirect_valid_i),
		.redirect_pc_i    (redirect_pc_i),
		.inst_ready_i     (inst_ready_i),
		.inst_valid_o     (inst_valid_o),
		.inst_o           (inst_o),
		.inst_pc_o        (inst_pc_o),
		.inst_illegal_o   (inst_illegal_o),
		.inst_fault_o     (inst_fault_o),
		.bus_req_o        (fetch_bus_req),
		.bus_rsp_i        (fetch_bus_rsp)
	);

	lsu_port i_lsu_port (
		.clk             (clk),
		.rst             (rst),
		.lsu_req_valid_i (lsu_req_valid_i),
		.lsu_req_i       (lsu_req_i),
		.lsu_req_ready_o (lsu_req_ready_o),
		.lsu_rsp_valid_o (lsu_rsp_valid_o),
		.lsu_err_o       (lsu_err_o),
		.lsu_rdata_o     (lsu_rdata_o),
		.bus_req_o       (lsu_bus_req),
		.bus_rsp_i       (lsu_bus_rsp)
	);

	// fetch is master 0, load/store is master 1
	axi_lite_arbiter i_axi_lite_arbiter (
		.clk      (clk),
		.rst      (rst),
		.m0_req_i (fetch_bus_req),
		.m1_req_i (lsu_bus_req),
		.m0_rsp_o (fetch_bus_rsp),
		.m1_rsp_o (lsu_bus_rsp),
		.s_req_o  (mem_req),
		.s_rsp_i  (mem_rsp)
	);

	axi_lite_sram #(
		.MEM_WORDS (MEM_WORDS)
	) i_axi_lite_sram (
		.clk     (clk),
		.rst     (rst),
		.s_req_i (mem_req),
		.s_rsp_o (mem_rsp)
	);

endmodule

`default_nettype wire

//--- verif/fetch_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_assert (
	input logic                    clk,
	input logic                    rst,
	input axi_lite_pkg::axil_req_t m0_req_i,
	input axi_lite_pkg::axil_req_t m1_req_i,
	input axi_lite_pkg::axil_rsp_t m0_rsp_i,
	input axi_lite_pkg::axil_rsp_t m1_rsp_i,
	input axi_lite_pkg::axil_req_t s_req_i,
	input axi_lite_pkg::axil_rsp_t s_rsp_i
);
	import axi_lite_pkg::*;

	logic m0_busy;
	logic m1_busy;
	logic ar_fire;

	// a master sees any ready or valid only while it holds the grant
	assign m0_busy = m0_rsp_i.ar_ready || m0_rsp_i.r_valid || m0_rsp_i.aw_ready ||
		m0_rsp_i.w_ready || m0_rsp_i.b_valid;
	assign m1_busy = m1_rsp_i.ar_ready || m1_rsp_i.r_valid || m1_rsp_i.aw_ready ||
		m1_rsp_i.w_ready || m1_rsp_i.b_valid;
	assign ar_fire = s_req_i.ar_valid && s_rsp_i.ar_ready;

	ar_hold_m0: assert property (@(posedge clk) disable iff (rst)
		m0_req_i.ar_valid && !m0_rsp_i.ar_ready |=>
		m0_req_i.ar_valid && $stable(m0_req_i.ar_addr))
		else $error("fetch read address dropped or changed before ready");

	ar_hold_m1: assert property (@(posedge clk) disable iff (rst)
		m1_req_i.ar_valid && !m1_rsp_i.ar_ready |=>
		m1_req_i.ar_valid && $stable(m1_req_i.ar_addr))
		else $error("load read address dropped or changed before ready");

	aw_hold_m1: assert property (@(posedge clk) disable iff (rst)
		m1_req_i.aw_valid && !m1_rsp_i.aw_ready |=>
		m1_req_i.aw_valid && $stable(m1_req_i.aw_addr) &&
		$stable(m1_req_i.w_data) && $stable(m1_req_i.w_strb))
		else $error("store request dropped or changed before ready");

	// a master waiting on its response still holds the grant, alone
	grant_held_m0: assert property (@(posedge clk) disable iff (rst)
		m0_req_i.r_ready |-> m0_rsp_i.r_valid && !m1_busy)
		else $error("fetch master lost the grant before its read data");

	grant_held_m1: assert property (@(posedge clk) disable iff (rst)
		(m1_req_i.r_ready || m1_req_i.b_ready) |->
		(m1_rsp_i.r_valid || m1_rsp_i.b_valid) && !m0_busy)
		else $error("load/store master lost the grant before its response");

	r_after_ar: assert property (@(posedge clk) disable iff (rst)
		ar_fire |=> s_rsp_i.r_valid)
		else $error("read data did not follow the address by one cycle");

	r_only_after_ar: assert property (@(posedge clk) disable iff (rst)
		$rose(s_rsp_i.r_valid) |-> $past(ar_fire))
		else $error("read data raised without an address handshake");

endmodule

`default_nettype wire

//--- verif/tb_fetch_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_mem;
	import axi_lite_pkg::*;

	localparam logic [31:0] RESET_PC   = 32'h0000_0040;
	localparam int          MEM_WORDS  = 256;
	localparam logic [31:0] DATA_BASE  = 32'h0000_0200;
	localparam logic [31:0] REDIR_BASE = 32'h0000_0300;
	localparam logic [31:0] OOR_BASE   = 32'(MEM_WORDS * 4);  // first address past memory
	localparam int          PROG_WORDS = 32;
	localparam int          LIMIT      = 400;  // cycles per wait

	logic        clk;
	logic        rst;
	logic        fetch_en;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic        inst_ready;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] inst_pc;
	logic        inst_illegal;
	logic        inst_fault;
	logic        lsu_req_valid;
	lsu_req_t    lsu_req;
	logic        lsu_req_ready;
	logic        lsu_rsp_valid;
	logic        lsu_err;
	logic [31:0] lsu_rdata;

	logic [31:0] shadow [MEM_WORDS];  // mirror of every store
	logic [31:0] rand_state;

	fetch_mem_top #(
		.RESET_PC  (RESET_PC),
		.MEM_WORDS (MEM_WORDS)
	) i_fetch_mem_top (
		.clk              (clk),
		.rst              (rst),
		.fetch_en_i       (fetch_en),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.inst_ready_i     (inst_ready),
		.inst_valid_o     (inst_valid),
		.inst_o           (inst),
		.inst_pc_o        (inst_pc),
		.inst_illegal_o   (inst_illegal),
		.inst_fault_o     (inst_fault),
		.lsu_req_valid_i  (lsu_req_valid),
		.lsu_req_i        (lsu_req),
		.lsu_req_ready_o  (lsu_req_ready),
		.lsu_rsp_valid_o  (lsu_rsp_valid),
		.lsu_err_o        (lsu_err),
		.lsu_rdata_o      (lsu_rdata)
	);

	bind axi_lite_arbiter fetch_mem_assert i_fetch_mem_assert (
		.clk      (clk),
		.rst      (rst),
		.m0_req_i (m0_req_i),
		.m1_req_i (m1_req_i),
		.m0_rsp_i (m0_rsp_o),
		.m1_rsp_i (m1_rsp_o),
		.s_req_i  (s_req_o),
		.s_rsp_i  (s_rsp_i)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// mostly real opcodes with random fields, so both legal and illegal words show up
	function automatic logic [31:0] make_inst(input logic [31:0] r);
		logic [6:0]  op;
		logic [6:0]  f7;
		logic [31:0] w;
		op = r[6:0];
		f7 = r[26] ? 7'h20 : 7'h00;
		if (r[25:24] == 2'b11)
			f7 = r[22:16];
		case (r[31:28])
			4'd0: op = 7'h37;
			4'd1: op = 7'h17;
			4'd2: op = 7'h6f;
			4'd3: op = 7'h67;
			4'd4: op = 7'h63;
			4'd5: op = 7'h03;
			4'd6: op = 7'h23;
			4'd7, 4'd8: op = 7'h13;
			4'd9, 4'd10: op = 7'h33;
			4'd11, 4'd12: op = 7'h73;
			default: f7 = r[31:25];  // plain random word
		endcase
		w = {f7, r[24:7], op};
		if (r[31:28] == 4'd12)
			w = r[27] ? 32'h0010_0073 : 32'h3020_0073;  // ebreak or mret
		if (r[31:28] == 4'd11 && r[27])
			w = 32'h0000_0073;  // ecall
		return w;
	endfunction

	function automatic logic expect_illegal(input logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ok;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			7'h37, 7'h17, 7'h6f: ok = 1'b1;
			7'h67: ok = (f3 == 3'd0);
			7'h63: ok = (f3 != 3'd2) && (f3 != 3'd3);
			7'h03: ok = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
			7'h23: ok = (f3 <= 3'd2);
			7'h13: begin
				if (f3 == 3'd1)
					ok = (f7 == 7'h00);
				else if (f3 == 3'd5)
					ok = (f7 == 7'h00) || (f7 == 7'h20);
				else
					ok = 1'b1;
			end
			7'h33: ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			7'h73: ok = (w == 32'h0000_0073) || (w == 32'h0010_0073) || (w == 32'h3020_0073);
			default: ok = 1'b0;
		endcase
		return !ok;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else fail_now($sformatf("FAIL %0t %s expected %h got %h", $time, name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else fail_now($sformatf("FAIL %0t %s expected %b got %b", $time, name, expected, actual));
	endtask

	task automatic redirect_to(input logic [31:0] pc);
		redirect_valid = 1'b1;
		redirect_pc    = pc;
		@(negedge clk);
		redirect_valid = 1'b0;
	endtask

	// one request, called on a falling edge, returns on the edge that shows the response
	task automatic lsu_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [31:0] rdata, output logic err);
		int n;
		n = 0;
		while (!lsu_req_ready) begin
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_now("timeout, load/store port never became ready");
		end
		lsu_req_valid = 1'b1;
		lsu_req.write = wr;
		lsu_req.addr  = addr;
		lsu_req.wdata = data;
		lsu_req.strb  = strb;
		@(negedge clk);
		lsu_req_valid = 1'b0;
		n = 0;
		while (!lsu_rsp_valid) begin
			@(negedge clk);
			n++;
			if (n > LIMIT)
				fail_now("timeout, no load/store response");
		end
		rdata = lsu_rdata;
		err   = lsu_err;
	endtask

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] rdata;
		logic        err;
		int          idx;
		lsu_access(1'b1, addr, data, strb, rdata, err);
		check_bit("lsu_err_o", 1'b0, err);
		idx = int'(addr[31:2]);
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				shadow[idx][8*b +: 8] = data[8*b +: 8];
		end
	endtask

	task automatic load_check(input logic [31:0] addr);
		logic [31:0] rdata;
		logic        err;
		lsu_access(1'b0, addr, 32'h0, 4'h0, rdata, err);
		check_word("lsu_rdata_o", shadow[int'(addr[31:2])], rdata);
		check_bit("lsu_err_o", 1'b0, err);
	endtask

	// strobed store to a random data word, then read it back
	task automatic mixed_traffic(input int count);
		logic [31:0] r;
		logic [31:0] addr;
		for (int k = 0; k < count; k++) begin
			r    = next_rand();
			addr = DATA_BASE + {26'd0, r[19:16], 2'b00};
			store_word(addr, next_rand(), r[23:20]);
			load_check(addr);
		end
	endtask

	task automatic consume_words(input logic [31:0] start_pc, input int count, input logic stall);
		logic [31:0] exp_pc;
		logic [31:0] exp_word;
		logic [31:0] held_inst;
		logic [31:0] held_pc;
		logic [31:0] r;
		logic        held;
		logic        exp_fault;
		int          got;
		int          idle;
		int          low_left;
		int          widx;
		exp_pc   = start_pc;
		got      = 0;
		idle     = 0;
		low_left = 0;
		held     = 1'b0;
		while (got < count) begin
			@(negedge clk);
			if (inst_valid) begin
				if (held) begin
					check_word("inst_o", held_inst, inst);  // unconsumed word holds
					check_word("inst_pc_o", held_pc, inst_pc);
				end
				widx      = int'(exp_pc[31:2]);
				exp_fault = (widx >= MEM_WORDS);
				if (exp_fault)
					exp_word = 32'h0;
				else
					exp_word = shadow[widx];
				check_word("inst_pc_o", exp_pc, inst_pc);
				check_word("inst_o", exp_word, inst);
				check_bit("inst_illegal_o", expect_illegal(exp_word), inst_illegal);
				check_bit("inst_fault_o", exp_fault, inst_fault);
			end
			if (stall && low_left == 0) begin
				r = next_rand();
				if (r[21])
					low_left = int'(r[18:16]);  // start a low stretch
			end
			inst_ready = (low_left == 0);
			if (low_left > 0)
				low_left--;
			if (inst_valid && inst_ready) begin
				got++;
				exp_pc = exp_pc + 32'd4;
				held   = 1'b0;
				idle   = 0;
			end else begin
				held      = inst_valid;
				held_inst = inst;
				held_pc   = inst_pc;
				idle++;
				if (idle > LIMIT)
					fail_now("timeout waiting for a fetched instruction");
			end
		end
		@(negedge clk);
		inst_ready = 1'b0;
	endtask

	initial begin
		logic [31:0] rd;
		logic        err;
		clk            = 1'b0;
		rst            = 1'b1;
		fetch_en       = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = 32'h0;
		inst_ready     = 1'b0;
		lsu_req_valid  = 1'b0;
		lsu_req        = '0;
		rand_state     = 32'd26583;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// word stores, strobed stores, read back
		for (int i = 0; i < 16; i++)
			store_word(DATA_BASE + 32'(4 * i), next_rand(), 4'hf);
		mixed_traffic(24);
		for (int i = 0; i < 16; i++)
			load_check(DATA_BASE + 32'(4 * i));

		// program and redirect target regions
		for (int i = 0; i < PROG_WORDS; i++)
			store_word(RESET_PC + 32'(4 * i), make_inst(next_rand()), 4'hf);
		for (int i = 0; i < 8; i++)
			store_word(REDIR_BASE + 32'(4 * i), make_inst(next_rand()), 4'hf);

		fetch_en = 1'b1;
		consume_words(RESET_PC, 12, 1'b0);
		redirect_to(REDIR_BASE);  // next read already on the bus
		consume_words(REDIR_BASE, 4, 1'b0);
		redirect_to(RESET_PC);
		consume_words(RESET_PC, 16, 1'b1);

		fork
			consume_words(RESET_PC + 32'd64, 12, 1'b1);
			mixed_traffic(10);
		join

		lsu_access(1'b0, OOR_BASE, 32'h0, 4'h0, rd, err);
		check_bit("lsu_err_o", 1'b1, err);
		check_word("lsu_rdata_o", 32'h0, rd);
		lsu_access(1'b1, OOR_BASE + DATA_BASE, next_rand(), 4'hf, rd, err);
		check_bit("lsu_err_o", 1'b1, err);
		load_check(DATA_BASE);  // alias of the rejected store
		redirect_to(OOR_BASE);  // drops the word on offer
		consume_words(OOR_BASE, 2, 1'b0);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/rv_isa_pkg.sv
logic/axi_lite_pkg.sv
logic/inst_check.sv
logic/fetch_unit.sv
logic/lsu_port.sv
logic/axi_lite_arbiter.sv
logic/axi_lite_sram.sv
logic/fetch_mem_top.sv
verif/fetch_mem_assert.sv
verif/tb_fetch_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_fetch_mem -f filelist.f -o tb_fetch_mem_sim

out=$(./obj_dir/tb_fetch_mem_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Simulation PASSED"
